/* design/arkpad_consts.svh */
// Player-input front end constants
// Scan codes, joystick bit positions, the DIP download index,
// spinner divider defaults and d-pad speeds
`ifndef ARKPAD_CONSTS_SVH
`define ARKPAD_CONSTS_SVH

// PS/2 set 2 scan codes of the game keys
`define ARK_KEY_START1  8'h16  // 1
`define ARK_KEY_START2  8'h1E  // 2
`define ARK_KEY_COIN1   8'h2E  // 5
`define ARK_KEY_COIN2   8'h36  // 6
`define ARK_KEY_SERVICE 8'h46  // 9
`define ARK_KEY_FAST    8'h11  // Alt
`define ARK_KEY_LEFT    8'h6B  // Cursor left
`define ARK_KEY_RIGHT   8'h74  // Cursor right
`define ARK_KEY_FIRE    8'h29  // Space

// Download index carrying the DIP bytes
`define ARK_DIP_INDEX   8'd254

// Half-rate ticks per spinner step and per d-pad poll
`define ARK_STEP_DIV    1500
`define ARK_POLL_DIV    48000

// Pending travel loaded per d-pad poll
`define ARK_DPAD_SLOW   4
`define ARK_DPAD_FAST   9

// Digital joystick bit positions (bits 2 and 3 unused)
`define ARK_JOY_RIGHT   0
`define ARK_JOY_LEFT    1
`define ARK_JOY_FIRE    4
`define ARK_JOY_FAST    5
`define ARK_JOY_START1  6
`define ARK_JOY_COIN    7
`define ARK_JOY_START2  8

`endif

/* design/arkpad_pkg.sv */
// Player-input front end types
// Packet layouts from the PS/2 side, spinner travel and quadrature
package arkpad_pkg;

	// [10] toggle per event, [9] pressed, [7:0] scan code
	typedef logic [10:0] ps2_key_t;

	// [24] toggle per packet, [15:8] X motion, [4] X sign, [1:0] buttons
	typedef logic [24:0] mouse_pkt_t;

	typedef logic [7:0] key_code_t;

	// Right, left, -, -, fire, fast, start 1, coin, start 2
	typedef logic [8:0] joy_t;

	// Signed travel still to be played out on the spinner
	typedef logic signed [11:0] paddle_pos_t;

	typedef logic [7:0] dip_t;   // One DIP switch bank
	typedef logic [1:0] quad_t;  // {B, A} quadrature lines

	// Gray sequence with forward order Q00 -> Q01 -> Q11 -> Q10 -> Q00
	typedef enum logic [1:0] {
		Q00 = 2'b00,
		Q01 = 2'b01,
		Q11 = 2'b11,
		Q10 = 2'b10
	} quad_phase_e;

endpackage

/* design/key_decoder.sv */
// PS/2 keyboard decoder
// Holds the pressed state of the nine game keys from key event packets
`include "arkpad_consts.svh"

module key_decoder (
	input  logic                 CLK_12M,
	input  logic                 rst,
	input  arkpad_pkg::ps2_key_t ps2_key,
	output logic                 key_fire,
	output logic                 key_left,
	output logic                 key_right,
	output logic                 key_fast,
	output logic                 key_coin1,
	output logic                 key_coin2,
	output logic                 key_service,
	output logic                 key_start1,
	output logic                 key_start2
);

	logic                  tgl_q;    // Toggle bit seen last cycle
	logic                  key_evt;  // New packet this cycle
	logic                  pressed;
	arkpad_pkg::key_code_t code;

	assign key_evt = ps2_key[10] != tgl_q;
	assign pressed = ps2_key[9];
	assign code    = ps2_key[7:0];

	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			tgl_q       <= 1'b0;
			key_fire    <= 1'b0;
			key_left    <= 1'b0;
			key_right   <= 1'b0;
			key_fast    <= 1'b0;
			key_coin1   <= 1'b0;
			key_coin2   <= 1'b0;
			key_service <= 1'b0;
			key_start1  <= 1'b0;
			key_start2  <= 1'b0;
		end else begin
			tgl_q <= ps2_key[10];
			if (key_evt) begin
				// Make or break sets the key to the pressed bit
				case (code)
					`ARK_KEY_START1:  key_start1  <= pressed;
					`ARK_KEY_START2:  key_start2  <= pressed;
					`ARK_KEY_COIN1:   key_coin1   <= pressed;
					`ARK_KEY_COIN2:   key_coin2   <= pressed;
					`ARK_KEY_SERVICE: key_service <= pressed;
					`ARK_KEY_FAST:    key_fast    <= pressed;
					`ARK_KEY_LEFT:    key_left    <= pressed;
					`ARK_KEY_RIGHT:   key_right   <= pressed;
					`ARK_KEY_FIRE:    key_fire    <= pressed;
					default: ;  // Other keys leave all states alone
				endcase
			end
		end
	end

endmodule

/* design/paddle_emulator.sv */
// Emulated spinner
// Accumulates mouse X and d-pad travel, then drains it one quadrature
// phase per step at half the system clock rate
`include "arkpad_consts.svh"

module paddle_emulator #(
	parameter int STEP_DIV = 1500,   // Half-rate ticks per spinner step
	parameter int POLL_DIV = 48000   // Half-rate ticks per d-pad reload
) (
	input  logic                   CLK_12M,
	input  logic                   rst,
	input  arkpad_pkg::mouse_pkt_t ps2_mouse,
	input  logic                   pad_left,
	input  logic                   pad_right,
	input  logic                   pad_fast,
	output arkpad_pkg::quad_t      emu_quad,
	output logic                   mouse_moved
);

	localparam int STEP_W = $clog2(STEP_DIV + 1);
	localparam int POLL_W = $clog2(POLL_DIV + 1);

	logic                    ce;         // Half-rate enable at 6 MHz
	logic [STEP_W-1:0]       step_cnt;
	logic [POLL_W-1:0]       poll_cnt;
	logic                    mouse_tgl_q;
	arkpad_pkg::paddle_pos_t position;   // Pending travel with its sign as direction
	arkpad_pkg::paddle_pos_t pos_next;
	arkpad_pkg::paddle_pos_t mouse_dx;
	arkpad_pkg::paddle_pos_t dpad_speed;
	arkpad_pkg::quad_phase_e phase;
	logic                    step_now;
	logic                    fwd;
	logic                    room;
	logic                    pad_held;
	logic                    poll_load;

	//////////////////////////////////////////////////
	// Event decode

	assign mouse_moved = ce && (ps2_mouse[24] != mouse_tgl_q);  // One pulse per packet
	assign mouse_dx    = {{4{ps2_mouse[4]}}, ps2_mouse[15:8]};   // 9-bit signed X
	assign room        = position[11] == position[10];            // Not near saturation
	assign pad_held    = pad_left | pad_right;
	assign poll_load   = ce && pad_held && (poll_cnt == POLL_W'(POLL_DIV - 1));
	assign dpad_speed  = pad_fast ? 12'(`ARK_DPAD_FAST) : 12'(`ARK_DPAD_SLOW);
	assign step_now    = ce && (step_cnt == '0) && (position != '0);
	assign fwd         = position[11];  // Negative travel steps forward

	//////////////////////////////////////////////////
	// Position update where later sources take priority

	always_comb begin
		pos_next = position;
		if (step_now)
			pos_next = fwd ? position + 12'sd1 : position - 12'sd1;  // Toward zero
		if (mouse_moved && room)
			pos_next = pos_next + mouse_dx;
		if (poll_load)
			pos_next = pad_right ? dpad_speed : -dpad_speed;  // Right wins if both
	end

	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			ce          <= 1'b0;
			step_cnt    <= '0;
			poll_cnt    <= '0;
			mouse_tgl_q <= 1'b0;
			position    <= '0;
			phase       <= arkpad_pkg::Q11;
		end else begin
			ce       <= ~ce;
			position <= pos_next;
			if (ce) begin
				mouse_tgl_q <= ps2_mouse[24];
				step_cnt    <= (step_cnt == STEP_W'(STEP_DIV - 1)) ? '0 : step_cnt + 1'b1;
				if (!pad_held || poll_load)
					poll_cnt <= '0;  // Restart the poll period
				else
					poll_cnt <= poll_cnt + 1'b1;
			end
			if (step_now) begin
				case (phase)
					arkpad_pkg::Q00: phase <= fwd ? arkpad_pkg::Q01 : arkpad_pkg::Q10;
					arkpad_pkg::Q01: phase <= fwd ? arkpad_pkg::Q11 : arkpad_pkg::Q00;
					arkpad_pkg::Q11: phase <= fwd ? arkpad_pkg::Q10 : arkpad_pkg::Q01;
					arkpad_pkg::Q10: phase <= fwd ? arkpad_pkg::Q00 : arkpad_pkg::Q11;
				endcase
			end
		end
	end

	assign emu_quad = arkpad_pkg::quad_t'(phase);

endmodule

/* design/encoder_halver.sv */
// External AB encoder rate halver
// Re-encodes the user-port encoder with one output phase per A edge,
// giving half the input count, and flags any input motion
module encoder_halver (
	input  logic              CLK_12M,
	input  logic              rst,
	input  arkpad_pkg::quad_t user_enc,  // {B, A}
	output arkpad_pkg::quad_t enc_quad,
	output logic              enc_moved
);

	arkpad_pkg::quad_t       enc_q;  // Inputs from last cycle
	arkpad_pkg::quad_phase_e phase;
	logic                    a_edge;
	logic                    fwd;

	assign a_edge    = user_enc[0] != enc_q[0];
	assign fwd       = user_enc[0] ^ user_enc[1];  // A against B sets direction
	assign enc_moved = user_enc != enc_q;          // Either line moved

	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			enc_q <= 2'b11;  // Idle lines are pulled up
			phase <= arkpad_pkg::Q11;
		end else begin
			enc_q <= user_enc;
			if (a_edge) begin
				// B edges are dropped, which halves the count
				case (phase)
					arkpad_pkg::Q00: phase <= fwd ? arkpad_pkg::Q01 : arkpad_pkg::Q10;
					arkpad_pkg::Q01: phase <= fwd ? arkpad_pkg::Q11 : arkpad_pkg::Q00;
					arkpad_pkg::Q11: phase <= fwd ? arkpad_pkg::Q10 : arkpad_pkg::Q01;
					arkpad_pkg::Q10: phase <= fwd ? arkpad_pkg::Q00 : arkpad_pkg::Q11;
				endcase
			end
		end
	end

	assign enc_quad = arkpad_pkg::quad_t'(phase);

endmodule

/* design/input_control.sv */
// Input control
// Merges keyboard, joystick and mouse buttons into active-low board
// inputs, picks the spinner source and holds the first DIP byte
`include "arkpad_consts.svh"

module input_control (
	input  logic              CLK_12M,
	input  logic              rst,
	input  logic              key_fire,
	input  logic              key_left,
	input  logic              key_right,
	input  logic              key_fast,
	input  logic              key_coin1,
	input  logic              key_coin2,
	input  logic              key_service,
	input  logic              key_start1,
	input  logic              key_start2,
	input  arkpad_pkg::joy_t  joy,
	input  logic [1:0]        mouse_buttons,
	input  logic              fire_n_ext,
	input  logic              enc_enable,
	input  arkpad_pkg::quad_t emu_quad,
	input  logic              mouse_moved,
	input  arkpad_pkg::quad_t enc_quad,
	input  logic              enc_moved,
	input  logic              ioctl_wr,
	input  logic [24:0]       ioctl_addr,
	input  arkpad_pkg::dip_t  ioctl_dout,
	input  logic [7:0]        ioctl_index,
	output logic              pad_left,
	output logic              pad_right,
	output logic              pad_fast,
	output arkpad_pkg::quad_t spinner,
	output logic              shot_n,
	output logic              coin1_n,
	output logic              coin2_n,
	output logic              service_n,
	output logic              start1_n,
	output logic              start2_n,
	output arkpad_pkg::dip_t  dip_sw
);

	logic             enc_mode;  // Spinner taken from the user-port encoder
	arkpad_pkg::dip_t dip_q;     // Bank 0 as downloaded, active low

	//////////////////////////////////////////////////
	// Button merge

	assign pad_left  = key_left  | joy[`ARK_JOY_LEFT];
	assign pad_right = key_right | joy[`ARK_JOY_RIGHT];
	assign pad_fast  = key_fast  | joy[`ARK_JOY_FAST];

	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			shot_n    <= 1'b1;
			coin1_n   <= 1'b1;
			coin2_n   <= 1'b1;
			service_n <= 1'b1;
			start1_n  <= 1'b1;
			start2_n  <= 1'b1;
		end else begin
			// Fire also from either mouse button or the user-port switch
			shot_n    <= ~(key_fire | joy[`ARK_JOY_FIRE] | (|mouse_buttons) | ~fire_n_ext);
			coin1_n   <= ~(key_coin1 | joy[`ARK_JOY_COIN]);
			coin2_n   <= ~key_coin2;    // Keyboard only
			service_n <= ~key_service;  // Keyboard only
			start1_n  <= ~(key_start1 | joy[`ARK_JOY_START1]);
			start2_n  <= ~(key_start2 | joy[`ARK_JOY_START2]);
		end
	end

	//////////////////////////////////////////////////
	// Spinner source and DIP bank

	always_ff @(posedge CLK_12M) begin
		if (rst) begin
			enc_mode <= 1'b0;
			dip_q    <= '0;
		end else begin
			if (mouse_moved || pad_left || pad_right)
				enc_mode <= 1'b0;  // Emulated input reclaims the spinner
			if (enc_moved)
				enc_mode <= 1'b1;
			if (!enc_enable)
				enc_mode <= 1'b0;
			if (ioctl_wr && ioctl_index == `ARK_DIP_INDEX && ioctl_addr == '0)
				dip_q <= ioctl_dout;
		end
	end

	assign spinner = enc_mode ? enc_quad : emu_quad;
	assign dip_sw  = ~dip_q;  // Board reads switches active low

endmodule

/* design/arkpad_top.sv */
// Player-input front end top level
// Keyboard decoder, emulated spinner and encoder halver feeding the
// control block that drives the game board inputs
`include "arkpad_consts.svh"

module arkpad_top #(
	parameter int STEP_DIV = `ARK_STEP_DIV,
	parameter int POLL_DIV = `ARK_POLL_DIV
) (
	input  logic                   CLK_12M,
	input  logic                   rst,
	input  arkpad_pkg::ps2_key_t   ps2_key,
	input  arkpad_pkg::mouse_pkt_t ps2_mouse,
	input  arkpad_pkg::joy_t       joy,
	input  logic [3:0]             user_in,  // [1:0] encoder, [3] fire low
	input  logic                   enc_enable,
	input  logic                   ioctl_wr,
	input  logic [24:0]            ioctl_addr,
	input  arkpad_pkg::dip_t       ioctl_dout,
	input  logic [7:0]             ioctl_index,
	output arkpad_pkg::quad_t      spinner,
	output logic                   shot_n,
	output logic                   coin1_n,
	output logic                   coin2_n,
	output logic                   service_n,
	output logic                   start1_n,
	output logic                   start2_n,
	output arkpad_pkg::dip_t       dip_sw
);

	logic key_fire, key_left, key_right, key_fast;
	logic key_coin1, key_coin2, key_service, key_start1, key_start2;
	logic pad_left, pad_right, pad_fast;
	logic mouse_moved, enc_moved;
	arkpad_pkg::quad_t emu_quad, enc_quad;

	key_decoder key_decoder_inst (
		.CLK_12M(CLK_12M), .rst(rst), .ps2_key(ps2_key),
		.key_fire(key_fire), .key_left(key_left), .key_right(key_right),
		.key_fast(key_fast), .key_coin1(key_coin1), .key_coin2(key_coin2),
		.key_service(key_service), .key_start1(key_start1), .key_start2(key_start2)
	);

	paddle_emulator #(.STEP_DIV(STEP_DIV), .POLL_DIV(POLL_DIV)) paddle_emulator_inst (
		.CLK_12M(CLK_12M), .rst(rst), .ps2_mouse(ps2_mouse),
		.pad_left(pad_left), .pad_right(pad_right), .pad_fast(pad_fast),
		.emu_quad(emu_quad), .mouse_moved(mouse_moved)
	);

	encoder_halver encoder_halver_inst (
		.CLK_12M(CLK_12M), .rst(rst), .user_enc(user_in[1:0]),
		.enc_quad(enc_quad), .enc_moved(enc_moved)
	);

	input_control input_control_inst (
		.CLK_12M(CLK_12M), .rst(rst),
		.key_fire(key_fire), .key_left(key_left), .key_right(key_right),
		.key_fast(key_fast), .key_coin1(key_coin1), .key_coin2(key_coin2),
		.key_service(key_service), .key_start1(key_start1), .key_start2(key_start2),
		.joy(joy), .mouse_buttons(ps2_mouse[1:0]), .fire_n_ext(user_in[3]),
		.enc_enable(enc_enable), .emu_quad(emu_quad), .mouse_moved(mouse_moved),
		.enc_quad(enc_quad), .enc_moved(enc_moved),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_index(ioctl_index),
		.pad_left(pad_left), .pad_right(pad_right), .pad_fast(pad_fast),
		.spinner(spinner), .shot_n(shot_n), .coin1_n(coin1_n), .coin2_n(coin2_n),
		.service_n(service_n), .start1_n(start1_n), .start2_n(start2_n),
		.dip_sw(dip_sw)
	);

endmodule

/* dv/arkpad_tb.sv */
// Player-input front end testbench
// Random keys, mouse motion, d-pad, external encoder and DIP writes,
// checked against a reference model and a spinner phase counter
`include "arkpad_consts.svh"

module arkpad_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STEP_DIV    = 4;
	localparam int POLL_DIV    = 16;
	localparam int CLK_HALF    = 20;   // 40 ns period
	localparam int DRIVE_DLY   = 2;    // Inputs change after the edge
	localparam int MAX_X       = 40;
	localparam int SETTLE_IDLE = (MAX_X + 1) * STEP_DIV * 2;  // Beyond a full drain
	localparam int SETTLE_LIMIT = 4 * SETTLE_IDLE;
	localparam int N_KEYS      = 150;
	localparam int N_MOUSE     = 30;
	localparam int N_DPAD      = 4;
	localparam int N_ENC       = 120;
	localparam int N_DIP       = 60;
	localparam int N_TESTS     = N_KEYS + N_MOUSE + N_DPAD + N_ENC + N_DIP + 3;
	localparam int WATCHDOG_NS = N_TESTS * SETTLE_LIMIT * 2 * CLK_HALF * 2;

	// Model slot order is fire, coin1, coin2, service, start1, start2, left, right, fast
	localparam logic [7:0] KEY_CODES [9] = '{`ARK_KEY_FIRE, `ARK_KEY_COIN1,
		`ARK_KEY_COIN2, `ARK_KEY_SERVICE, `ARK_KEY_START1, `ARK_KEY_START2,
		`ARK_KEY_LEFT, `ARK_KEY_RIGHT, `ARK_KEY_FAST};

	logic                   CLK_12M;
	logic                   rst;
	arkpad_pkg::ps2_key_t   ps2_key;
	arkpad_pkg::mouse_pkt_t ps2_mouse;
	arkpad_pkg::joy_t       joy;
	logic [3:0]             user_in;
	logic                   enc_enable;
	logic                   ioctl_wr;
	logic [24:0]            ioctl_addr;
	arkpad_pkg::dip_t       ioctl_dout;
	logic [7:0]             ioctl_index;
	arkpad_pkg::quad_t      spinner;
	logic                   shot_n, coin1_n, coin2_n, service_n, start1_n, start2_n;
	arkpad_pkg::dip_t       dip_sw;

	logic [31:0]       rng_state;
	logic [8:0]        model_keys;   // Held key states as the model sees them
	arkpad_pkg::dip_t  model_dip;    // Last byte written to bank 0
	int                steps;        // Net forward phase moves on spinner
	logic              tracking;     // Phase counter running
	arkpad_pkg::quad_t prev_quad;
	int                delta;

	arkpad_top #(.STEP_DIV(STEP_DIV), .POLL_DIV(POLL_DIV)) arkpad_top_inst (
		.CLK_12M(CLK_12M), .rst(rst), .ps2_key(ps2_key), .ps2_mouse(ps2_mouse),
		.joy(joy), .user_in(user_in), .enc_enable(enc_enable),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_index(ioctl_index), .spinner(spinner), .shot_n(shot_n),
		.coin1_n(coin1_n), .coin2_n(coin2_n), .service_n(service_n),
		.start1_n(start1_n), .start2_n(start2_n), .dip_sw(dip_sw)
	);

	always #CLK_HALF CLK_12M = ~CLK_12M;

	//////////////////////////////////////////////////
	// Helpers

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	task automatic next_cycles(input int n);
		repeat (n) @(posedge CLK_12M);
		#DRIVE_DLY;
	endtask

	// Position in the forward order Q00, Q01, Q11, Q10
	function automatic int phase_index(input arkpad_pkg::quad_t q);
		case (q)
			2'b00: return 0;
			2'b01: return 1;
			2'b11: return 2;
			default: return 3;
		endcase
	endfunction

	function automatic int key_slot(input arkpad_pkg::key_code_t code);
		for (int i = 0; i < 9; i++)
			if (KEY_CODES[i] == code)
				return i;
		return -1;  // Not a game key
	endfunction

	// Active-low board buttons in the order shot, coin1, coin2, service, start1, start2
	function automatic logic [5:0] expected_buttons();
		logic fire;
		fire = model_keys[0] | joy[`ARK_JOY_FIRE] | (|ps2_mouse[1:0]) | ~user_in[3];
		return ~{fire, model_keys[1] | joy[`ARK_JOY_COIN], model_keys[2], model_keys[3],
			model_keys[4] | joy[`ARK_JOY_START1], model_keys[5] | joy[`ARK_JOY_START2]};
	endfunction

	task automatic check_quad(input arkpad_pkg::quad_t exp, input arkpad_pkg::quad_t act);
		if (exp !== act)
			stop_run($sformatf("error spinner expected %h got %h", exp, act));
	endtask

	task automatic check_buttons(input logic [5:0] exp, input logic [5:0] act);
		if (exp !== act)
			stop_run($sformatf("error buttons expected %h got %h", exp, act));
	endtask

	task automatic check_dip(input arkpad_pkg::dip_t exp, input arkpad_pkg::dip_t act);
		if (exp !== act)
			stop_run($sformatf("error dip_sw expected %h got %h", exp, act));
	endtask

	task automatic check_steps(input arkpad_pkg::paddle_pos_t exp,
			input arkpad_pkg::paddle_pos_t act);
		if (exp !== act)
			stop_run($sformatf("error spinner steps expected %h got %h", exp, act));
	endtask

	// Counts phase moves mid-cycle away from the edges
	always @(negedge CLK_12M) begin
		if (tracking && spinner != prev_quad) begin
			delta = (phase_index(spinner) - phase_index(prev_quad) + 4) % 4;
			if (delta == 1)
				steps = steps + 1;
			else if (delta == 3)
				steps = steps - 1;
			else
				stop_run("spinner jumped two phases in one cycle");
		end
		prev_quad = spinner;
	end

	task automatic resync_steps();
		tracking = 1'b0;
		@(negedge CLK_12M);  // Counter takes the current phase
		next_cycles(1);
		steps    = 0;
		tracking = 1'b1;
	endtask

	// Spinner must stay still for longer than a full drain
	task automatic wait_settled();
		int                idle;
		int                waited;
		arkpad_pkg::quad_t last;
		idle   = 0;
		waited = 0;
		last   = spinner;
		while (idle < SETTLE_IDLE) begin
			next_cycles(1);
			waited++;
			if (waited > SETTLE_LIMIT)
				stop_run("spinner still moving after the settle limit");
			else if (spinner == last)
				idle++;
			else begin
				idle = 0;
				last = spinner;
			end
		end
	endtask

	task automatic send_key(input arkpad_pkg::key_code_t code, input logic pressed);
		int slot;
		slot    = key_slot(code);
		ps2_key = {~ps2_key[10], pressed, 1'b0, code};  // Toggle marks the event
		if (slot >= 0)
			model_keys[slot] = pressed;
	endtask

	//////////////////////////////////////////////////
	// Tests

	task automatic key_events();
		logic [31:0] r;
		arkpad_pkg::key_code_t code;
		repeat (N_KEYS) begin
			r = xorshift32();
			code = (r[3:0] < 4'd9) ? KEY_CODES[r[3:0]] : r[15:8];  // Some unknown codes
			joy = r[24:16];
			user_in[3] = r[25] | r[26];  // External fire mostly idle
			ps2_mouse[1:0] = r[27] ? r[29:28] : 2'b00;  // Mouse buttons now and then
			send_key(code, r[4]);
			next_cycles(4);
			check_buttons(expected_buttons(), {shot_n, coin1_n, coin2_n, service_n,
				start1_n, start2_n});
		end
		for (int i = 0; i < 9; i++) begin
			send_key(KEY_CODES[i], 1'b0);  // Release everything
			next_cycles(1);
		end
		joy            = '0;
		user_in[3]     = 1'b1;
		ps2_mouse[1:0] = 2'b00;
		next_cycles(4);
		check_buttons(6'h3F, {shot_n, coin1_n, coin2_n, service_n, start1_n, start2_n});
		wait_settled();  // D-pad presses may still drain
	endtask

	task automatic mouse_motion();
		logic [31:0] r;
		int x;
		repeat (N_MOUSE) begin
			resync_steps();
			r = xorshift32();
			x = int'(r[15:0] % 16'd81) - MAX_X;
			ps2_mouse[15:8] = 8'(x);
			ps2_mouse[4]    = (x < 0);
			ps2_mouse[24]   = ~ps2_mouse[24];
			wait_settled();
			check_steps(arkpad_pkg::paddle_pos_t'(-x), arkpad_pkg::paddle_pos_t'(steps));
		end
	endtask

	task automatic dpad_holds();
		logic [31:0] r;
		logic right;
		for (int i = 0; i < N_DPAD; i++) begin
			resync_steps();
			r     = xorshift32();
			right = (i % 2) == 0;
			joy   = '0;
			joy[`ARK_JOY_RIGHT] = right;
			joy[`ARK_JOY_LEFT]  = ~right;
			joy[`ARK_JOY_FAST]  = r[4];
			next_cycles(3 * POLL_DIV * 2 + int'(r[3:0]));  // Several reloads
			joy = '0;
			wait_settled();
			if (right && steps >= 0)
				stop_run("d-pad right did not give a negative phase count");
			else if (!right && steps <= 0)
				stop_run("d-pad left did not give a positive phase count");
		end
	endtask

	task automatic encoder_drive();
		logic [31:0] r;
		arkpad_pkg::quad_t emu_idle;
		int enc_model;
		emu_idle   = spinner;
		tracking   = 1'b0;
		enc_enable = 1'b1;
		next_cycles(1);
		user_in[1] = ~user_in[1];  // B move alone takes over the spinner
		next_cycles(2);
		resync_steps();
		enc_model = 0;
		repeat (N_ENC) begin
			r = xorshift32();
			if (r[0]) begin
				user_in[0] = ~user_in[0];
				enc_model  = enc_model + ((user_in[0] ^ user_in[1]) ? 1 : -1);
			end else
				user_in[1] = ~user_in[1];  // B edges are not counted
			next_cycles(1 + int'(r[2:1]));
		end
		wait_settled();
		check_steps(arkpad_pkg::paddle_pos_t'(enc_model), arkpad_pkg::paddle_pos_t'(steps));
		tracking   = 1'b0;
		enc_enable = 1'b0;
		next_cycles(2);
		check_quad(emu_idle, spinner);  // Back on the emulated source
		repeat (2) begin
			user_in[0] = ~user_in[0];  // Encoder moves no longer reach the spinner
			next_cycles(2);
			check_quad(emu_idle, spinner);
		end
		resync_steps();
	endtask

	task automatic dip_writes();
		logic [31:0] r;
		logic [31:0] d;
		repeat (N_DIP) begin
			r = xorshift32();
			d = xorshift32();
			ioctl_index = (r[1:0] == 2'b00) ? r[15:8] : `ARK_DIP_INDEX;
			ioctl_addr  = (r[3:2] == 2'b00) ? {12'h000, r[28:16]} : 25'h0;
			ioctl_dout  = d[7:0];
			ioctl_wr    = 1'b1;
			next_cycles(1);
			ioctl_wr = 1'b0;
			if (ioctl_index == 8'd254 && ioctl_addr == 25'h0)
				model_dip = ioctl_dout;
			next_cycles(1);
			check_dip(~model_dip, dip_sw);
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence

	initial begin
		CLK_12M     = 1'b0;
		rst         = 1'b1;
		ps2_key     = '0;
		ps2_mouse   = '0;
		joy         = '0;
		user_in     = 4'b1111;  // Encoder idle high and fire released
		enc_enable  = 1'b0;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		ioctl_index = '0;
		rng_state   = 32'd68290;
		model_keys  = '0;
		model_dip   = '0;
		steps       = 0;
		tracking    = 1'b0;
		prev_quad   = 2'b11;
		next_cycles(8);
		rst = 1'b0;
		check_quad(arkpad_pkg::quad_t'(arkpad_pkg::Q11), spinner);
		check_buttons(6'h3F, {shot_n, coin1_n, coin2_n, service_n, start1_n, start2_n});
		check_dip(8'hFF, dip_sw);
		key_events();
		mouse_motion();
		dpad_holds();
		encoder_drive();
		dip_writes();
		$display("TB PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		stop_run("watchdog expired before the tests finished");
	end

endmodule

/* list.f */
+incdir+design
design/arkpad_pkg.sv
design/key_decoder.sv
design/paddle_emulator.sv
design/encoder_halver.sv
design/input_control.sv
design/arkpad_top.sv
dv/arkpad_tb.sv

/* run.sh */
#!/bin/sh
# Build the player-input testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module arkpad_tb -Mdir obj_dir -o arkpad_sim -f list.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/arkpad_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
